//--- mycpu_top.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mycpu_top.sv
dv/tb_mycpu_top.sv

//--- dv/tb_mycpu_top.sv
// rom model, reference ISA model and trace checker for the core
// every program ends in a self-loop branch whose delay slot is a nop
`timescale 1ns/1ps

module tb_mycpu_top
    import cpu_pkg::*;
();

    localparam word_t BOOT_PC   = 32'hbfc0_0000;
    localparam int    ROM_WORDS = 256;

    typedef struct packed {
        word_t     pc;
        reg_addr_t num;
        word_t     data;
    } trace_t;

    logic      aclk;
    logic      rst;
    word_t     inst_addr;
    word_t     inst_data;
    word_t     debug_wb_pc;
    word_t     debug_wb_rf_wdata;
    wen_t      debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;

    word_t  rom [0:ROM_WORDS-1];
    int     rom_len;
    word_t  fetch_addr_q;  // address presented during the last cycle
    trace_t exp_q [$];
    string  cur_test;
    word_t  lcg_state = 32'h49c4;
    int     error_count = 0;
    int     test_count = 0;
    int     failed_tests = 0;
    int     cycle_count;
    int     cycle_limit = 0;  // grows as each test is queued

    mycpu_top #(
        .reset_pc (BOOT_PC)
    ) dut (
        .aclk              (aclk),
        .rst               (rst),
        .inst_addr         (inst_addr),
        .inst_data         (inst_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #2 aclk = ~aclk;

    // synchronous rom with one cycle from address to data
    always @(posedge aclk) begin
        #1;
        inst_data = fetch_word(fetch_addr_q);
        fetch_addr_q = inst_addr;
    end

    function automatic word_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - BOOT_PC) >> 2;
        if (idx < ROM_WORDS) begin
            return rom[idx];
        end
        return '0;  // outside the program reads as nop
    endfunction

    function automatic word_t r_type(input logic [5:0] fn, input int rd, input int rs, input int rt);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input int rt, input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic void emit(input word_t inst);
        rom[rom_len] = inst;
        rom_len++;
    endfunction

    // target is a rom word index and the offset counts from the delay slot
    function automatic void branch_to(input logic [5:0] op, input int rs, input int rt,
                                      input int target);
        emit(i_type(op, rt, rs, target - rom_len - 1));
    endfunction

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // architectural model with delay slot that fills exp_q
    function automatic void build_expected();
        word_t     regs [0:31];
        word_t     pc;
        word_t     npc;
        word_t     inst;
        word_t     a;
        word_t     b;
        word_t     sext;
        word_t     result;
        reg_addr_t dst;
        logic      writes;
        logic      taken;
        trace_t    entry;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_q.delete();
        pc  = BOOT_PC;
        npc = BOOT_PC + 32'd4;
        for (int step = 0; step < 4 * ROM_WORDS; step++) begin
            inst   = fetch_word(pc);
            a      = regs[inst[25:21]];
            b      = regs[inst[20:16]];
            sext   = {{16{inst[15]}}, inst[15:0]};
            dst    = inst[20:16];
            writes = 1'b1;
            taken  = 1'b0;
            result = '0;
            case (inst[31:26])
                OP_SPECIAL: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        FN_ADDU: result = a + b;
                        FN_SUBU: result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        FN_XOR:  result = a ^ b;
                        FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                OP_ADDIU: result = a + sext;
                OP_ORI:   result = a | {16'h0000, inst[15:0]};
                OP_LUI:   result = {inst[15:0], 16'h0000};
                OP_BEQ: begin
                    writes = 1'b0;
                    taken  = (a == b);
                end
                OP_BNE: begin
                    writes = 1'b0;
                    taken  = (a != b);
                end
                default: writes = 1'b0;
            endcase
            if (writes && (dst != 5'd0)) begin
                regs[dst]  = result;
                entry.pc   = pc;
                entry.num  = dst;
                entry.data = result;
                exp_q.push_back(entry);
            end
            if (taken && (pc + 32'd4 + (sext << 2)) == pc) begin
                break;  // end-of-program loop
            end
            pc  = npc;
            npc = taken ? (npc + (sext << 2)) : (npc + 32'd4);
        end
    endfunction

    task automatic check_word(input string field, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s expected %h actual %h", cur_test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_reg(input string field, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s expected %0d actual %0d", cur_test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_wen(input string field, input wen_t expected, input wen_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s expected %b actual %b", cur_test, field, expected, actual);
            error_count++;
        end
    endtask

    // trace comparator samples values before the edge updates them
    always @(posedge aclk) begin
        trace_t want;
        if (debug_wb_rf_wen != 4'h0) begin
            if (exp_q.size() == 0) begin
                $display("%s: unexpected trace entry at pc %h writing r%0d",
                         cur_test, debug_wb_pc, debug_wb_rf_wnum);
                error_count++;
            end else begin
                want = exp_q.pop_front();
                check_word("pc", want.pc, debug_wb_pc);
                check_reg("wnum", want.num, debug_wb_rf_wnum);
                check_word("wdata", want.data, debug_wb_rf_wdata);
                check_wen("wen", 4'hf, debug_wb_rf_wen);  // full word write
            end
        end
    end

    // 4 cycles per trace entry plus 20 per test
    initial begin
        cycle_count = 0;
        wait (cycle_limit != 0);  // first test queues its budget
        while (cycle_count < cycle_limit) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d trace entries of %s never retired",
                 cycle_count, exp_q.size(), cur_test);
        $display("TEST FAILED");
        $finish;
    end

    task automatic start_program(input string name);
        @(posedge aclk);
        #1;
        rst      = 1'b1;
        cur_test = name;
        rom_len  = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
    endtask

    task automatic run_program();
        int errors_before;
        int entries;
        branch_to(OP_BEQ, 0, 0, rom_len);  // self loop
        emit('0);                          // its delay slot
        build_expected();
        entries       = exp_q.size();
        cycle_limit   += 4 * entries + 20;
        errors_before = error_count;
        repeat (3) @(posedge aclk);
        #1;
        rst = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge aclk);
            #1;
        end
        repeat (8) @(posedge aclk);  // window for stray writes
        #1;
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("%-14s %0d trace entries, %0d errors", cur_test, entries,
                 error_count - errors_before);
    endtask

    task automatic random_program(input int count);
        word_t r;
        word_t imm;
        int    rd;
        int    rs;
        int    rt;
        for (int n = 0; n < count; n++) begin
            r   = next_random();
            imm = next_random();
            rd  = r[18:16];  // r0..r7 keeps hazards dense
            rs  = r[21:19];
            rt  = r[24:22];
            case (r[31:25] % 9)
                0: emit(r_type(FN_ADDU, rd, rs, rt));
                1: emit(r_type(FN_SUBU, rd, rs, rt));
                2: emit(r_type(FN_AND, rd, rs, rt));
                3: emit(r_type(FN_OR, rd, rs, rt));
                4: emit(r_type(FN_XOR, rd, rs, rt));
                5: emit(r_type(FN_SLT, rd, rs, rt));
                6: emit(i_type(OP_ADDIU, rt, rs, imm[31:16]));
                7: emit(i_type(OP_ORI, rt, rs, imm[31:16]));
                default: emit(i_type(OP_LUI, rt, 0, imm[31:16]));
            endcase
        end
    endtask

    initial begin
        aclk         = 1'b0;
        rst          = 1'b1;
        inst_data    = '0;
        fetch_addr_q = BOOT_PC;

        start_program("dependent_alu");
        emit(i_type(OP_ADDIU, 1, 0, 100));
        emit(i_type(OP_ADDIU, 2, 0, -7));
        emit(r_type(FN_ADDU, 3, 1, 2));   // r1 two back, r2 one back
        emit(r_type(FN_SUBU, 4, 3, 1));
        emit(r_type(FN_AND, 5, 4, 3));
        emit(r_type(FN_OR, 6, 5, 4));
        emit(r_type(FN_XOR, 7, 6, 2));
        emit(r_type(FN_SLT, 8, 2, 1));    // negative below positive
        emit(r_type(FN_SLT, 9, 1, 2));
        emit(r_type(FN_SUBU, 10, 0, 1));
        emit(r_type(FN_SLT, 11, 10, 4));  // both negative
        run_program();

        start_program("immediates");
        emit(i_type(OP_ADDIU, 1, 0, 16'h8000));
        emit(i_type(OP_ORI, 2, 0, 16'h8000));
        emit(i_type(OP_LUI, 3, 0, 16'h1234));
        emit(i_type(OP_ORI, 3, 3, 16'h5678));
        emit(i_type(OP_ADDIU, 4, 3, -1));
        emit(i_type(OP_LUI, 5, 0, 16'hffff));
        emit(i_type(OP_ORI, 6, 5, 16'hffff));
        emit(i_type(OP_ADDIU, 7, 6, 1));
        run_program();

        start_program("taken_branch");
        emit(i_type(OP_ADDIU, 1, 0, 5));
        emit(i_type(OP_ADDIU, 2, 0, 5));
        branch_to(OP_BEQ, 1, 2, rom_len + 4);
        emit(i_type(OP_ADDIU, 3, 0, 1));  // delay slot
        emit(i_type(OP_ADDIU, 4, 0, 2));
        emit(i_type(OP_ADDIU, 5, 0, 3));
        emit(i_type(OP_ADDIU, 6, 0, 7));
        branch_to(OP_BNE, 1, 6, rom_len + 3);
        emit(i_type(OP_ADDIU, 7, 0, 4));
        emit(i_type(OP_ADDIU, 8, 0, 9));
        emit(i_type(OP_ADDIU, 10, 0, 3));
        emit(i_type(OP_ADDIU, 10, 10, -1));  // backward loop body
        branch_to(OP_BNE, 10, 0, rom_len - 1);
        emit(r_type(FN_ADDU, 11, 11, 10));
        run_program();

        start_program("not_taken");
        emit(i_type(OP_ADDIU, 1, 0, 1));
        emit(i_type(OP_ADDIU, 2, 0, 2));
        branch_to(OP_BEQ, 1, 2, rom_len + 4);
        emit(i_type(OP_ADDIU, 3, 0, 3));
        emit(i_type(OP_ADDIU, 4, 0, 4));
        emit(i_type(OP_ADDIU, 5, 0, 5));
        branch_to(OP_BNE, 1, 1, rom_len + 3);
        emit(i_type(OP_ADDIU, 6, 0, 6));
        emit(i_type(OP_ADDIU, 7, 0, 7));
        emit(r_type(FN_ADDU, 8, 1, 2));
        run_program();

        start_program("zero_register");
        emit(i_type(OP_ADDIU, 1, 0, 7));
        emit(i_type(OP_ADDIU, 0, 0, 55));
        emit(r_type(FN_ADDU, 2, 0, 1));  // r0 right after a write to it
        emit(i_type(OP_ORI, 0, 0, 16'hffff));
        emit(r_type(FN_OR, 3, 0, 0));
        emit(i_type(OP_LUI, 0, 0, 16'h1234));
        emit(i_type(OP_ADDIU, 4, 0, 1));
        run_program();

        start_program("random_alu");
        random_program(200);
        run_program();

        $display("tests run %0d, tests with errors %0d, failed checks %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/mycpu_top.sv
// three-stage integer core: fetch, decode, execute with a trace register
// inst_data must be the rom word for the address of the previous cycle
`timescale 1ns/1ps

module mycpu_top
    import cpu_pkg::*;
#(
    parameter word_t reset_pc = 32'hbfc0_0000
) (
    input  logic      aclk,
    input  logic      rst,
    output word_t     inst_addr,
    input  word_t     inst_data,
    output word_t     debug_wb_pc,
    output word_t     debug_wb_rf_wdata,
    output wen_t      debug_wb_rf_wen,
    output reg_addr_t debug_wb_rf_wnum
);

    word_t     id_pc;
    logic      id_valid;
    logic      branch_taken;
    word_t     branch_target;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    logic      ex_valid;
    word_t     ex_pc;
    alu_op_t   ex_alu_op;
    word_t     ex_src_a;
    word_t     ex_src_b;
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    word_t     ex_imm;
    logic      ex_use_imm;
    reg_addr_t ex_dst;
    logic      ex_reg_wr;
    logic      ex_is_beq;
    logic      ex_is_bne;

    logic      wb_valid;
    word_t     wb_pc;
    logic      wb_wr;
    reg_addr_t wb_dst;
    word_t     wb_data;

    // golden trace straight from the wb register
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_data;
    assign debug_wb_rf_wen   = (wb_valid && wb_wr) ? 4'b1111 : 4'b0000;  // full word only
    assign debug_wb_rf_wnum  = wb_dst;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .aclk          (aclk),
        .rst           (rst),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .inst_addr     (inst_addr),
        .id_pc         (id_pc),
        .id_valid      (id_valid)
    );

    decode_stage u_decode (
        .aclk       (aclk),
        .rst        (rst),
        .inst_data  (inst_data),
        .id_pc      (id_pc),
        .id_valid   (id_valid),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .ex_valid   (ex_valid),
        .ex_pc      (ex_pc),
        .ex_alu_op  (ex_alu_op),
        .ex_src_a   (ex_src_a),
        .ex_src_b   (ex_src_b),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_imm     (ex_imm),
        .ex_use_imm (ex_use_imm),
        .ex_dst     (ex_dst),
        .ex_reg_wr  (ex_reg_wr),
        .ex_is_beq  (ex_is_beq),
        .ex_is_bne  (ex_is_bne)
    );

    reg_file u_reg_file (
        .aclk    (aclk),
        .rst     (rst),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_wr   (wb_wr),
        .wb_dst  (wb_dst),
        .wb_data (wb_data)
    );

    execute_stage u_execute (
        .aclk          (aclk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_alu_op     (ex_alu_op),
        .ex_src_a      (ex_src_a),
        .ex_src_b      (ex_src_b),
        .ex_rs         (ex_rs),
        .ex_rt         (ex_rt),
        .ex_imm        (ex_imm),
        .ex_use_imm    (ex_use_imm),
        .ex_dst        (ex_dst),
        .ex_reg_wr     (ex_reg_wr),
        .ex_is_beq     (ex_is_beq),
        .ex_is_bne     (ex_is_bne),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_wr         (wb_wr),
        .wb_dst        (wb_dst),
        .wb_data       (wb_data)
    );

endmodule

//--- verilog/execute_stage.sv
// forwards from the writeback register, runs the alu and resolves branches
// the wb register doubles as the golden-trace record
`timescale 1ns/1ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic      aclk,
    input  logic      rst,
    input  logic      ex_valid,
    input  word_t     ex_pc,
    input  alu_op_t   ex_alu_op,
    input  word_t     ex_src_a,
    input  word_t     ex_src_b,
    input  reg_addr_t ex_rs,
    input  reg_addr_t ex_rt,
    input  word_t     ex_imm,
    input  logic      ex_use_imm,
    input  reg_addr_t ex_dst,
    input  logic      ex_reg_wr,
    input  logic      ex_is_beq,
    input  logic      ex_is_bne,
    output logic      branch_taken,
    output word_t     branch_target,
    output logic      wb_valid,
    output word_t     wb_pc,
    output logic      wb_wr,
    output reg_addr_t wb_dst,
    output word_t     wb_data
);

    word_t fwd_a;
    word_t fwd_b;
    word_t alu_b;
    word_t alu_y;
    logic  wb_fwd_ok;
    logic  ops_equal;

    // previous instruction still in wb, not yet visible in the register file
    assign wb_fwd_ok = wb_valid && wb_wr && (wb_dst != 5'd0);

    always_comb begin
        fwd_a = ex_src_a;
        fwd_b = ex_src_b;
        if (wb_fwd_ok && (wb_dst == ex_rs)) begin
            fwd_a = wb_data;
        end
        if (wb_fwd_ok && (wb_dst == ex_rt)) begin
            fwd_b = wb_data;
        end
    end

    assign alu_b = ex_use_imm ? ex_imm : fwd_b;

    alu u_alu (
        .op (ex_alu_op),
        .a  (fwd_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    assign ops_equal     = (fwd_a == fwd_b);
    assign branch_taken  = ex_valid && ((ex_is_beq && ops_equal) || (ex_is_bne && !ops_equal));
    assign branch_target = ex_pc + 32'd4 + {ex_imm[29:0], 2'b00};  // relative to delay slot

    always_ff @(posedge aclk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_wr    <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_wr    <= ex_reg_wr;  // already gated by valid in decode
        end
    end

    always_ff @(posedge aclk) begin
        wb_pc   <= ex_pc;
        wb_dst  <= ex_dst;
        wb_data <= alu_y;
    end

endmodule

//--- verilog/decode_stage.sv
// decodes the kept integer subset and registers operands for execute
// unknown opcodes pass as valid but never write a register
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic      aclk,
    input  logic      rst,
    input  word_t     inst_data,
    input  word_t     id_pc,
    input  logic      id_valid,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output logic      ex_valid,
    output word_t     ex_pc,
    output alu_op_t   ex_alu_op,
    output word_t     ex_src_a,
    output word_t     ex_src_b,
    output reg_addr_t ex_rs,
    output reg_addr_t ex_rt,
    output word_t     ex_imm,
    output logic      ex_use_imm,
    output reg_addr_t ex_dst,
    output logic      ex_reg_wr,
    output logic      ex_is_beq,
    output logic      ex_is_bne
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rd;
    logic [15:0] imm16;
    word_t       imm_sext;
    word_t       imm_zext;

    alu_op_t   dec_alu_op;
    word_t     dec_imm;
    logic      dec_use_imm;
    reg_addr_t dec_dst;
    logic      dec_writes;
    logic      dec_is_beq;
    logic      dec_is_bne;

    assign opcode   = inst_data[31:26];
    assign rs_addr  = inst_data[25:21];  // register file read, same cycle
    assign rt_addr  = inst_data[20:16];
    assign rd       = inst_data[15:11];
    assign funct    = inst_data[5:0];
    assign imm16    = inst_data[15:0];
    assign imm_sext = {{16{imm16[15]}}, imm16};
    assign imm_zext = {16'h0000, imm16};

    always_comb begin
        dec_alu_op  = ALU_ADD;
        dec_imm     = imm_sext;
        dec_use_imm = 1'b0;
        dec_dst     = rd;
        dec_writes  = 1'b0;
        dec_is_beq  = 1'b0;
        dec_is_bne  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dec_writes = 1'b1;
                case (funct)
                    FN_ADDU: dec_alu_op = ALU_ADD;
                    FN_SUBU: dec_alu_op = ALU_SUB;
                    FN_AND:  dec_alu_op = ALU_AND;
                    FN_OR:   dec_alu_op = ALU_OR;
                    FN_XOR:  dec_alu_op = ALU_XOR;
                    FN_SLT:  dec_alu_op = ALU_SLT;
                    default: dec_writes = 1'b0;  // unsupported funct
                endcase
            end
            OP_ADDIU: begin
                dec_use_imm = 1'b1;
                dec_dst     = rt_addr;
                dec_writes  = 1'b1;
            end
            OP_ORI: begin
                dec_alu_op  = ALU_OR;
                dec_imm     = imm_zext;
                dec_use_imm = 1'b1;
                dec_dst     = rt_addr;
                dec_writes  = 1'b1;
            end
            OP_LUI: begin
                dec_alu_op  = ALU_LUI;
                dec_imm     = imm_zext;
                dec_use_imm = 1'b1;
                dec_dst     = rt_addr;
                dec_writes  = 1'b1;
            end
            OP_BEQ: dec_is_beq = 1'b1;  // compare in execute
            OP_BNE: dec_is_bne = 1'b1;
            default: ;
        endcase
    end

    // control part of the pipeline register
    always_ff @(posedge aclk) begin
        if (rst) begin
            ex_valid  <= 1'b0;
            ex_reg_wr <= 1'b0;
            ex_is_beq <= 1'b0;
            ex_is_bne <= 1'b0;
        end else begin
            ex_valid  <= id_valid;
            ex_reg_wr <= id_valid && dec_writes && (dec_dst != 5'd0);  // r0 never written
            ex_is_beq <= id_valid && dec_is_beq;
            ex_is_bne <= id_valid && dec_is_bne;
        end
    end

    always_ff @(posedge aclk) begin
        ex_pc      <= id_pc;
        ex_alu_op  <= dec_alu_op;
        ex_src_a   <= rs_data;
        ex_src_b   <= rt_data;
        ex_rs      <= rs_addr;
        ex_rt      <= rt_addr;
        ex_imm     <= dec_imm;
        ex_use_imm <= dec_use_imm;
        ex_dst     <= dec_dst;
    end

endmodule

//--- verilog/fetch_stage.sv
// pc and rom address; the rom answers one cycle after the address
// branches redirect one cycle late, so the delay slot is already in decode
`timescale 1ns/1ps

module fetch_stage
    import cpu_pkg::*;
#(
    parameter word_t reset_pc = 32'hbfc0_0000
) (
    input  logic  aclk,
    input  logic  rst,
    input  logic  branch_taken,   // from execute, same cycle
    input  word_t branch_target,
    output word_t inst_addr,
    output word_t id_pc,
    output logic  id_valid
);

    word_t pc;
    word_t pc_next;

    assign inst_addr = pc;  // rom address straight from the pc register

    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            pc       <= reset_pc;
            id_valid <= 1'b0;
        end else begin
            pc       <= pc_next;
            // word fetched during the branch's execute cycle is past the delay slot
            id_valid <= ~branch_taken;
        end
    end

    // address of the word the rom is returning now
    always_ff @(posedge aclk) begin
        id_pc <= pc;
    end

endmodule

//--- verilog/reg_file.sv
// 32 x 32 register file with r0 reading as zero
// a write in the same cycle is bypassed to both read ports
`timescale 1ns/1ps

module reg_file
    import cpu_pkg::*;
(
    input  logic      aclk,
    input  logic      rst,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      wb_wr,
    input  reg_addr_t wb_dst,
    input  word_t     wb_data
);

    word_t regs [1:31];  // no storage for r0

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wr && (wb_dst != 5'd0)) begin
            regs[wb_dst] <= wb_data;
        end
    end

    // same-cycle write covers the producer two instructions back
    assign rs_data = (rs_addr == 5'd0) ? '0 :
                     (wb_wr && (wb_dst == rs_addr)) ? wb_data : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? '0 :
                     (wb_wr && (wb_dst == rt_addr)) ? wb_data : regs[rt_addr];

endmodule

//--- verilog/alu.sv
// combinational alu for the kept integer operations
// add and sub wrap and never trap; unknown op codes give zero
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic lt_signed;

    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SLT: begin
                y = {31'd0, lt_signed};  // 0 or 1
            end
            ALU_LUI: begin
                y = {b[15:0], 16'h0000};  // a is ignored
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

//--- verilog/cpu_pkg.sv
// shared widths and encodings for the three-stage core
// only the integer subset below is decoded, everything else retires with no write
package cpu_pkg;

    typedef logic [31:0] word_t;      // data, pc and instruction
    typedef logic [4:0]  reg_addr_t;  // register number
    typedef logic [2:0]  alu_op_t;    // alu operation select
    typedef logic [3:0]  wen_t;       // trace byte write enable

    // alu operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;  // signed compare
    localparam alu_op_t ALU_LUI = 3'd6;  // b low half to upper half

    // opcode field, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;  // r-type, see funct
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function field, inst[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage
